// ==== src/cache_pkg.sv ====
// -----------------------------------------------
// address widths, address union and test pattern
// functions for the cache self-test
// -----------------------------------------------

package cache_pkg;

  localparam int addr_bits = 16;
  localparam int index_bits = 4;
  localparam int tag_bits = 10;
  localparam int byte_bits = addr_bits - tag_bits - index_bits;
  localparam int word_addr_bits = addr_bits - byte_bits;
  localparam int num_sets = 1 << index_bits;

  typedef logic [31:0] word_t;

  // one byte address, seen by the cache or by the memory
  typedef union packed {
    struct packed {
      logic [tag_bits-1:0] tag;
      logic [index_bits-1:0] index;
      logic [byte_bits-1:0] byte_sel;
    } cache;
    struct packed {
      logic [word_addr_bits-1:0] word_addr;
      logic [byte_bits-1:0] byte_sel;
    } mem;
  } cache_addr_u;

  // scrambled and partly inverted address groups
  function automatic word_t pattern_word(input logic [word_addr_bits-1:0] a);
    return {~a[1:0], a[5:2], 2'b00, ~a[9:6],
            a[13:10], a[9:6], 2'b11, ~a[13:10],
            a[1:0], ~a[5:2]};
  endfunction

  // byte 0 sits at the top of the word
  function automatic logic [7:0] pattern_byte(input word_t w,
                                              input logic [byte_bits-1:0] sel);
    case (sel)
      2'd0: return w[31:24];
      2'd1: return w[23:16];
      2'd2: return w[15:8];
      default: return w[7:0];
    endcase
  endfunction

endpackage

// ==== src/cache_exerciser.sv ====
// -----------------------------------------------
// burst request generator, response checker and
// per-burst hit/miss counters
// -----------------------------------------------
`timescale 1ns/1ps

module cache_exerciser (
  input  logic clk,
  input  logic rst,
  input  logic cmd_start,
  input  logic [cache_pkg::addr_bits-1:0] cmd_base,
  input  logic [15:0] cmd_stride,
  input  logic [15:0] cmd_count,
  input  logic [3:0] cmd_gap,
  output logic req_valid,
  output logic [cache_pkg::addr_bits-1:0] req_addr,
  input  logic req_ready,
  input  logic rsp_valid,
  input  logic [7:0] rsp_data,
  input  logic rsp_hit,
  output logic busy,
  output logic burst_done,
  output logic burst_error,
  output logic [15:0] burst_hits,
  output logic [15:0] burst_misses
);

  logic accept, xfer, last_issue, last_rsp;
  logic [15:0] stride_q, count_q, issued_q, rsp_cnt_q;
  logic [3:0] gap_q, gap_cnt_q;
  cache_pkg::cache_addr_u queue_q [2];
  cache_pkg::cache_addr_u head;
  logic wr_ptr_q, rd_ptr_q;
  logic [1:0] q_count_q;
  logic [7:0] expect_byte;

  assign accept = cmd_start & ~busy;
  assign xfer = req_valid & req_ready;
  assign last_issue = (issued_q == count_q - 16'd1);
  assign last_rsp = (rsp_cnt_q == count_q - 16'd1);

  // -----------------------------------------------
  // address sequencer and gap counter
  always_ff @(posedge clk) begin
    if (accept) begin
      req_addr <= cmd_base;
      stride_q <= cmd_stride;
      count_q <= cmd_count;
      gap_q <= cmd_gap;
    end else if (xfer) begin
      req_addr <= req_addr + stride_q;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      busy <= 1'b0;
      req_valid <= 1'b0;
      issued_q <= '0;
      gap_cnt_q <= '0;
    end else if (accept) begin
      busy <= 1'b1;
      req_valid <= 1'b1;
      issued_q <= '0;
      gap_cnt_q <= '0;
    end else begin
      if (xfer) begin
        issued_q <= issued_q + 16'd1;
        if (last_issue) begin
          req_valid <= 1'b0;
        end else if (gap_q != 4'd0) begin
          req_valid <= 1'b0;
          gap_cnt_q <= gap_q;
        end
      end else if (gap_cnt_q != 4'd0) begin
        gap_cnt_q <= gap_cnt_q - 4'd1;
        // last idle cycle, present the next request
        if (gap_cnt_q == 4'd1) req_valid <= 1'b1;
      end
      if (rsp_valid && last_rsp) busy <= 1'b0;
    end
  end

  // -----------------------------------------------
  // issued-address queue, at most two in flight
  always_ff @(posedge clk) begin
    if (xfer) queue_q[wr_ptr_q] <= req_addr;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr_q <= 1'b0;
      rd_ptr_q <= 1'b0;
      q_count_q <= '0;
    end else begin
      if (xfer) wr_ptr_q <= ~wr_ptr_q;
      if (rsp_valid) rd_ptr_q <= ~rd_ptr_q;
      q_count_q <= q_count_q + {1'b0, xfer} - {1'b0, rsp_valid};
    end
  end

  assign head = queue_q[rd_ptr_q];
  assign expect_byte = cache_pkg::pattern_byte(
      cache_pkg::pattern_word(head.mem.word_addr), head.mem.byte_sel);

  // response checker
  always_ff @(posedge clk) begin
    if (rst || accept) begin
      rsp_cnt_q <= '0;
      burst_done <= 1'b0;
      burst_error <= 1'b0;
      burst_hits <= '0;
      burst_misses <= '0;
    end else begin
      burst_done <= rsp_valid & last_rsp;
      if (rsp_valid) begin
        rsp_cnt_q <= rsp_cnt_q + 16'd1;
        if (rsp_data != expect_byte) burst_error <= 1'b1;
        if (rsp_hit) burst_hits <= burst_hits + 16'd1;
        else burst_misses <= burst_misses + 16'd1;
      end
    end
  end

  // the cache never lets more than two requests overlap
  a_queue_no_overflow: assert property (@(posedge clk) disable iff (rst)
      (xfer && !rsp_valid) |-> (q_count_q != 2'd2));
  a_rsp_has_request: assert property (@(posedge clk) disable iff (rst)
      rsp_valid |-> (q_count_q != 2'd0));

endmodule

// ==== src/cache_ctrl.sv ====
// -----------------------------------------------
// cache controller with request latch, miss FSM
// and refill writes into the victim way
// -----------------------------------------------
`timescale 1ns/1ps

module cache_ctrl #(
  parameter int NUM_WAYS = 2,
  parameter int MEM_LATENCY = 4
) (
  input  logic clk,
  input  logic rst,
  input  logic req_valid,
  input  logic [cache_pkg::addr_bits-1:0] req_addr,
  output logic req_ready,
  output logic rsp_valid,
  output logic [7:0] rsp_data,
  output logic rsp_hit,
  input  logic flush,
  output logic [cache_pkg::index_bits-1:0] lookup_index,
  output logic [cache_pkg::tag_bits-1:0] lookup_tag,
  input  logic hit,
  input  logic [7:0] hit_byte,
  input  logic [NUM_WAYS-1:0] victim_way,
  output logic [NUM_WAYS-1:0] fill_en,
  output logic [cache_pkg::index_bits-1:0] fill_index,
  output logic [cache_pkg::tag_bits-1:0] fill_tag,
  output cache_pkg::word_t fill_data,
  output logic flush_all,
  output logic mem_rd,
  output logic [cache_pkg::word_addr_bits-1:0] mem_word_addr,
  input  logic mem_ack,
  input  cache_pkg::word_t mem_data
);

  localparam logic [1:0] st_idle = 2'd0;
  localparam logic [1:0] st_wait_mem = 2'd1;
  localparam logic [1:0] st_respond = 2'd2;

  logic [1:0] state_q;
  logic xfer, refill;
  cache_pkg::cache_addr_u req_u;
  cache_pkg::cache_addr_u miss_q;
  cache_pkg::cache_addr_u look_u;

  assign req_u = req_addr;
  assign xfer = req_valid & req_ready;
  assign refill = (state_q == st_wait_mem) & mem_ack;

  // no new requests while the refill is outstanding
  assign req_ready = (state_q != st_wait_mem);

  // the miss set stays on the lookup so the victim is stable
  assign look_u = (state_q == st_wait_mem) ? miss_q : req_u;
  assign lookup_index = look_u.cache.index;
  assign lookup_tag = look_u.cache.tag;

  assign mem_word_addr = {miss_q.cache.tag, miss_q.cache.index};
  assign fill_index = miss_q.cache.index;
  assign fill_tag = miss_q.cache.tag;
  assign fill_data = mem_data;
  assign fill_en = {NUM_WAYS{refill}} & victim_way;
  assign flush_all = flush & (state_q != st_wait_mem);

  // -----------------------------------------------
  // miss FSM
  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= st_idle;
      mem_rd <= 1'b0;
    end else begin
      mem_rd <= 1'b0;
      case (state_q)
        st_idle, st_respond: begin
          if (xfer && !hit) begin
            state_q <= st_wait_mem;
            mem_rd <= 1'b1;
          end else begin
            state_q <= st_idle;
          end
        end
        st_wait_mem: begin
          if (mem_ack) state_q <= st_respond;
        end
        default: state_q <= st_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (xfer && !hit) miss_q <= req_u;
  end

  // response, from the lookup on a hit or from the refill word
  always_ff @(posedge clk) begin
    if (rst) begin
      rsp_valid <= 1'b0;
    end else begin
      rsp_valid <= (xfer & hit) | refill;
    end
  end

  always_ff @(posedge clk) begin
    if (refill) begin
      rsp_data <= cache_pkg::pattern_byte(mem_data, miss_q.cache.byte_sel);
      rsp_hit <= 1'b0;
    end else begin
      rsp_data <= hit_byte;
      rsp_hit <= 1'b1;
    end
  end

  // every memory answer belongs to the one miss still waiting
  a_ack_for_outstanding_miss: assert property (@(posedge clk) disable iff (rst)
      mem_ack |-> (state_q == st_wait_mem));
  a_mem_latency: assert property (@(posedge clk) disable iff (rst)
      mem_rd |-> ##MEM_LATENCY mem_ack);

endmodule

// ==== src/cache_way.sv ====
// -----------------------------------------------
// one cache way with valid, tag and data per set
// -----------------------------------------------
`timescale 1ns/1ps

module cache_way (
  input  logic clk,
  input  logic rst,
  input  logic [cache_pkg::index_bits-1:0] lookup_index,
  input  logic [cache_pkg::tag_bits-1:0] lookup_tag,
  input  logic fill_en,
  input  logic [cache_pkg::index_bits-1:0] fill_index,
  input  logic [cache_pkg::tag_bits-1:0] fill_tag,
  input  cache_pkg::word_t fill_data,
  input  logic flush_all,
  output logic way_hit,
  output cache_pkg::word_t way_data
);

  logic [cache_pkg::num_sets-1:0] valid_q;
  logic [cache_pkg::tag_bits-1:0] tag_q [cache_pkg::num_sets];
  cache_pkg::word_t data_q [cache_pkg::num_sets];

  // -----------------------------------------------
  // line state
  always_ff @(posedge clk) begin
    if (rst || flush_all) begin
      valid_q <= '0;
    end else if (fill_en) begin
      valid_q[fill_index] <= 1'b1;
    end
  end

  // tag and data arrays
  always_ff @(posedge clk) begin
    if (fill_en) begin
      tag_q[fill_index] <= fill_tag;
      data_q[fill_index] <= fill_data;
    end
  end

  // -----------------------------------------------
  // combinational tag compare
  assign way_hit = valid_q[lookup_index] & (tag_q[lookup_index] == lookup_tag);
  assign way_data = data_q[lookup_index];

endmodule

// ==== src/cache_hit_select.sv ====
// -----------------------------------------------
// way result merge and true LRU victim choice
// -----------------------------------------------
`timescale 1ns/1ps

module cache_hit_select #(
  parameter int NUM_WAYS = 2
) (
  input  logic clk,
  input  logic rst,
  input  logic [NUM_WAYS-1:0] way_hit,
  input  cache_pkg::word_t way_data [NUM_WAYS],
  input  logic [cache_pkg::index_bits-1:0] lookup_index,
  input  logic [cache_pkg::byte_bits-1:0] byte_sel,
  input  logic lookup_fire,
  input  logic fill_fire,
  output logic hit,
  output logic [7:0] hit_byte,
  output logic [NUM_WAYS-1:0] victim_way
);

  localparam int age_bits = (NUM_WAYS > 1) ? $clog2(NUM_WAYS) : 1;

  logic [age_bits-1:0] age_q [cache_pkg::num_sets][NUM_WAYS];
  logic [age_bits-1:0] promote_age;
  logic [NUM_WAYS-1:0] promote_oh;
  logic promote;
  cache_pkg::word_t hit_word;

  assign hit = |way_hit;
  assign promote = fill_fire | (lookup_fire & hit);
  assign promote_oh = fill_fire ? victim_way : way_hit;
  assign hit_byte = cache_pkg::pattern_byte(hit_word, byte_sel);

  // invalid ways are never promoted, so they always rank oldest
  always_comb begin
    hit_word = '0;
    victim_way = '0;
    promote_age = '0;
    for (int w = 0; w < NUM_WAYS; w++) begin
      if (way_hit[w]) hit_word = hit_word | way_data[w];
      if (age_q[lookup_index][w] == age_bits'(NUM_WAYS - 1)) victim_way[w] = 1'b1;
      if (promote_oh[w]) promote_age = age_q[lookup_index][w];
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int s = 0; s < cache_pkg::num_sets; s++) begin
        for (int w = 0; w < NUM_WAYS; w++) age_q[s][w] <= age_bits'(w);
      end
    end else if (promote) begin
      for (int w = 0; w < NUM_WAYS; w++) begin
        if (promote_oh[w]) age_q[lookup_index][w] <= '0;
        else if (age_q[lookup_index][w] < promote_age)
          age_q[lookup_index][w] <= age_q[lookup_index][w] + 1'b1;
      end
    end
  end

  a_way_hit_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(way_hit));

endmodule

// ==== src/pattern_mem.sv ====
// -----------------------------------------------
// backing memory answering with pattern words
// after a fixed latency
// -----------------------------------------------
`timescale 1ns/1ps

module pattern_mem #(
  parameter int MEM_LATENCY = 4
) (
  input  logic clk,
  input  logic rst,
  input  logic mem_rd,
  input  logic [cache_pkg::word_addr_bits-1:0] mem_word_addr,
  output logic mem_ack,
  output cache_pkg::word_t mem_data
);

  logic [MEM_LATENCY-1:0] rd_line_q;
  logic [cache_pkg::word_addr_bits-1:0] addr_line_q [MEM_LATENCY];

  // -----------------------------------------------
  // read strobe delay line
  always_ff @(posedge clk) begin
    if (rst) begin
      rd_line_q <= '0;
    end else begin
      rd_line_q[0] <= mem_rd;
      for (int i = 1; i < MEM_LATENCY; i++) begin
        rd_line_q[i] <= rd_line_q[i-1];
      end
    end
  end

  // address travels alongside the strobe
  always_ff @(posedge clk) begin
    addr_line_q[0] <= mem_word_addr;
    for (int i = 1; i < MEM_LATENCY; i++) begin
      addr_line_q[i] <= addr_line_q[i-1];
    end
  end

  // -----------------------------------------------
  // word computed as the read leaves the line
  assign mem_ack = rd_line_q[MEM_LATENCY-1];
  assign mem_data = cache_pkg::pattern_word(addr_line_q[MEM_LATENCY-1]);

endmodule

// ==== src/cache_selftest_top.sv ====
// -----------------------------------------------
// self-test top with exerciser, cache and memory
// -----------------------------------------------
`timescale 1ns/1ps

module cache_selftest_top #(
  parameter int NUM_WAYS = 2,
  parameter int MEM_LATENCY = 4
) (
  input  logic clk,
  input  logic rst,
  input  logic cmd_start,
  input  logic [cache_pkg::addr_bits-1:0] cmd_base,
  input  logic [15:0] cmd_stride,
  input  logic [15:0] cmd_count,
  input  logic [3:0] cmd_gap,
  input  logic cache_flush,
  output logic busy,
  output logic burst_done,
  output logic burst_error,
  output logic [15:0] burst_hits,
  output logic [15:0] burst_misses
);

  logic req_valid, req_ready, rsp_valid, rsp_hit;
  logic [cache_pkg::addr_bits-1:0] req_addr;
  logic [7:0] rsp_data, hit_byte;
  logic [cache_pkg::index_bits-1:0] lookup_index, fill_index;
  logic [cache_pkg::tag_bits-1:0] lookup_tag, fill_tag;
  logic [NUM_WAYS-1:0] fill_en, way_hit, victim_way;
  cache_pkg::word_t fill_data, mem_data;
  cache_pkg::word_t way_data [NUM_WAYS];
  logic flush_all, hit, mem_rd, mem_ack;
  logic [cache_pkg::word_addr_bits-1:0] mem_word_addr;

  cache_exerciser cache_exerciser_i (
    .clk, .rst, .cmd_start, .cmd_base, .cmd_stride, .cmd_count, .cmd_gap,
    .req_valid, .req_addr, .req_ready, .rsp_valid, .rsp_data, .rsp_hit,
    .busy, .burst_done, .burst_error, .burst_hits, .burst_misses
  );

  // flush is only honored between bursts
  cache_ctrl #(.NUM_WAYS(NUM_WAYS), .MEM_LATENCY(MEM_LATENCY)) cache_ctrl_i (
    .clk, .rst, .req_valid, .req_addr, .req_ready, .rsp_valid, .rsp_data, .rsp_hit,
    .flush(cache_flush & ~busy), .lookup_index, .lookup_tag, .hit, .hit_byte,
    .victim_way, .fill_en, .fill_index, .fill_tag, .fill_data, .flush_all,
    .mem_rd, .mem_word_addr, .mem_ack, .mem_data
  );

  for (genvar g = 0; g < NUM_WAYS; g++) begin : g_way
    cache_way cache_way_i (
      .clk, .rst, .lookup_index, .lookup_tag, .fill_en(fill_en[g]), .fill_index,
      .fill_tag, .fill_data, .flush_all, .way_hit(way_hit[g]), .way_data(way_data[g])
    );
  end

  cache_hit_select #(.NUM_WAYS(NUM_WAYS)) cache_hit_select_i (
    .clk, .rst, .way_hit, .way_data, .lookup_index, .byte_sel(req_addr[1:0]),
    .lookup_fire(req_valid & req_ready), .fill_fire(|fill_en),
    .hit, .hit_byte, .victim_way
  );

  pattern_mem #(.MEM_LATENCY(MEM_LATENCY)) pattern_mem_i (
    .clk, .rst, .mem_rd, .mem_word_addr, .mem_ack, .mem_data
  );

endmodule

// ==== bench/tb_cache_selftest.sv ====
// -----------------------------------------------
// testbench for the cache self-test top with burst
// list, 2-way LRU tag model and watchdog
// -----------------------------------------------
`timescale 1ns/1ps

module tb_cache_selftest;

  localparam int num_ways = 2;
  localparam int mem_latency = 4;
  localparam int num_random = 20;
  localparam int max_bursts = 32;
  localparam int burst_margin = 20;

  logic clk, rst, cmd_start, cache_flush;
  logic [15:0] cmd_base, cmd_stride, cmd_count;
  logic [3:0] cmd_gap;
  logic busy, burst_done, burst_error;
  logic [15:0] burst_hits, burst_misses;

  // burst list, built once before the run
  string b_name [max_bursts];
  logic [15:0] b_base [max_bursts];
  logic [15:0] b_stride [max_bursts];
  logic [15:0] b_count [max_bursts];
  logic [3:0] b_gap [max_bursts];
  bit b_flush [max_bursts];
  int num_bursts;

  int seed;
  int watchdog_cycles;
  bit watchdog_armed;
  int errors, test_errors, tests_passed, tests_failed;

  // model state, one recency-ordered pair of tags per set
  logic [9:0] mru_tag [16];
  logic [9:0] lru_tag [16];
  bit mru_v [16];
  bit lru_v [16];

  cache_selftest_top #(.NUM_WAYS(num_ways), .MEM_LATENCY(mem_latency)) cache_selftest_top_i (
    .clk, .rst, .cmd_start, .cmd_base, .cmd_stride, .cmd_count, .cmd_gap, .cache_flush,
    .busy, .burst_done, .burst_error, .burst_hits, .burst_misses
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // -----------------------------------------------
  // reference model
  task automatic model_flush();
    for (int s = 0; s < 16; s++) begin
      mru_v[s] = 1'b0;
      lru_v[s] = 1'b0;
    end
  endtask

  task automatic model_access(input logic [15:0] addr, output bit hit);
    logic [3:0] idx;
    logic [9:0] tag;
    idx = addr[5:2];
    tag = addr[15:6];
    hit = 1'b0;
    if (mru_v[idx] && mru_tag[idx] == tag) begin
      hit = 1'b1;
    end else if (lru_v[idx] && lru_tag[idx] == tag) begin
      hit = 1'b1;
      lru_tag[idx] = mru_tag[idx];
      mru_tag[idx] = tag;
    end else begin
      // refill replaces the least recently used line
      lru_tag[idx] = mru_tag[idx];
      lru_v[idx] = mru_v[idx];
      mru_tag[idx] = tag;
      mru_v[idx] = 1'b1;
    end
  endtask

  // -----------------------------------------------
  // compare tasks
  task automatic check_count(input string name, input logic [15:0] expected,
                             input logic [15:0] actual);
    if (actual !== expected) begin
      $display("FAIL %s: expected %0d, actual %0d", name, expected, actual);
      test_errors++;
    end
  endtask

  task automatic check_flag(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      $display("FAIL %s: expected %b, actual %b", name, expected, actual);
      test_errors++;
    end
  endtask

  function automatic int burst_bound(input logic [15:0] count, input logic [3:0] gap);
    return int'(count) * (int'(gap) + mem_latency + 3) + burst_margin;
  endfunction

  task automatic add_burst(input string name, input logic [15:0] base,
                           input logic [15:0] stride, input logic [15:0] count,
                           input logic [3:0] gap, input bit flush);
    b_name[num_bursts] = name;
    b_base[num_bursts] = base;
    b_stride[num_bursts] = stride;
    b_count[num_bursts] = count;
    b_gap[num_bursts] = gap;
    b_flush[num_bursts] = flush;
    num_bursts++;
  endtask

  task automatic build_bursts();
    logic [15:0] base, stride, count;
    logic [3:0] gap;
    num_bursts = 0;
    add_burst("sequential", 16'h0000, 16'h0001, 16'd64, 4'd0, 1'b0);
    // same set 0, 0x100 made most recent before 0x500 arrives
    add_burst("lru_fill", 16'h0100, 16'h0100, 16'd2, 4'd1, 1'b0);
    add_burst("lru_reuse", 16'h0200, 16'hff00, 16'd2, 4'd1, 1'b0);
    add_burst("lru_conflict", 16'h0500, 16'hfc00, 16'd2, 4'd1, 1'b0);
    for (int r = 0; r < num_random; r++) begin
      base = 16'($random(seed));
      stride = 16'($random(seed)) & 16'h001f;
      count = 16'(1 + {$random(seed)} % 40);
      gap = 4'($random(seed));
      add_burst($sformatf("random_%0d", r), base, stride, count, gap, 1'b0);
    end
    add_burst("flush_replay", 16'h0000, 16'h0001, 16'd64, 4'd0, 1'b1);
    add_burst("warm_up", 16'h1040, 16'h0001, 16'd40, 4'd3, 1'b0);
    add_burst("back_to_back", 16'h1040, 16'h0001, 16'd40, 4'd0, 1'b0);
  endtask

  // -----------------------------------------------
  // stimulus
  task automatic drive_flush();
    @(posedge clk);
    #10 cache_flush = 1'b1;
    @(posedge clk);
    #10 cache_flush = 1'b0;
  endtask

  task automatic run_burst(input int k);
    logic [15:0] addr, exp_hits, exp_misses;
    bit hit, done;
    int bound, cycles;
    exp_hits = '0;
    exp_misses = '0;
    done = 1'b0;
    cycles = 0;
    test_errors = 0;
    bound = burst_bound(b_count[k], b_gap[k]);
    if (b_flush[k]) begin
      drive_flush();
      model_flush();
    end
    addr = b_base[k];
    for (int i = 0; i < int'(b_count[k]); i++) begin
      model_access(addr, hit);
      if (hit) exp_hits++;
      else exp_misses++;
      addr = addr + b_stride[k];
    end
    @(posedge clk);
    #10;
    cmd_start = 1'b1;
    cmd_base = b_base[k];
    cmd_stride = b_stride[k];
    cmd_count = b_count[k];
    cmd_gap = b_gap[k];
    @(posedge clk);
    #10 cmd_start = 1'b0;
    // the accepted command makes the exerciser busy
    check_flag({b_name[k], " busy"}, 1'b1, busy);
    while (!done && cycles < bound) begin
      @(posedge clk);
      #10;
      done = burst_done;
      cycles++;
    end
    if (!done) begin
      $display("burst %s never signalled burst_done within %0d cycles", b_name[k], bound);
      test_errors++;
    end else begin
      check_count({b_name[k], " hits"}, exp_hits, burst_hits);
      check_count({b_name[k], " misses"}, exp_misses, burst_misses);
      check_flag({b_name[k], " error"}, 1'b0, burst_error);
      check_flag({b_name[k], " idle"}, 1'b0, busy);
    end
    if (test_errors == 0) begin
      $display("test %-14s passed (hits %0d, misses %0d)", b_name[k], burst_hits, burst_misses);
      tests_passed++;
    end else begin
      $display("test %-14s failed with %0d errors", b_name[k], test_errors);
      tests_failed++;
    end
    errors += test_errors;
  endtask

  // -----------------------------------------------
  // main sequence
  initial begin
    rst = 1'b1;
    cmd_start = 1'b0;
    cmd_base = '0;
    cmd_stride = '0;
    cmd_count = '0;
    cmd_gap = '0;
    cache_flush = 1'b0;
    seed = 32'h807;
    errors = 0;
    tests_passed = 0;
    tests_failed = 0;
    build_bursts();
    watchdog_cycles = 2 + burst_margin;
    for (int k = 0; k < num_bursts; k++) begin
      watchdog_cycles += burst_bound(b_count[k], b_gap[k]) + 4;
    end
    watchdog_armed = 1'b1;
    model_flush();
    repeat (2) @(posedge clk);
    #10 rst = 1'b0;
    for (int k = 0; k < num_bursts; k++) begin
      run_burst(k);
    end
    $display("tests %0d, passed %0d, failed %0d, errors %0d",
             num_bursts, tests_passed, tests_failed, errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  // watchdog over the summed burst bounds
  initial begin
    wait (watchdog_armed);
    repeat (watchdog_cycles) @(posedge clk);
    $display("watchdog expired after %0d cycles, the bursts did not complete", watchdog_cycles);
    $display("TEST FAILED");
    $finish;
  end

endmodule

// ==== build.f ====
src/cache_pkg.sv
src/cache_exerciser.sv
src/cache_ctrl.sv
src/cache_way.sv
src/cache_hit_select.sv
src/pattern_mem.sv
src/cache_selftest_top.sv
bench/tb_cache_selftest.sv

// ==== Bender.yml ====
package:
  name: cache_selftest

sources:
  - files:
      - src/cache_pkg.sv
      - src/cache_exerciser.sv
      - src/cache_ctrl.sv
      - src/cache_way.sv
      - src/cache_hit_select.sv
      - src/pattern_mem.sv
      - src/cache_selftest_top.sv
  - target: test
    files:
      - bench/tb_cache_selftest.sv
